/* design/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

  // Field widths of the 4 bank x 4096 row x 512 column x 32-bit part
  localparam int bank_w       = 2;
  localparam int row_w        = 12;
  localparam int col_w        = 9;
  localparam int data_w       = 32;
  localparam int sdram_addr_w = 12;

  // FPGA address is {bank, row, col}
  localparam int fpga_addr_w  = bank_w + row_w + col_w;

  // Command code on {cs_n, ras_n, cas_n, we_n}
  // Read and write carry auto precharge when A10 is high
  typedef enum logic [3:0] {
    cmd_load_mode = 4'b0000,
    cmd_refresh   = 4'b0001,
    cmd_precharge = 4'b0010,
    cmd_active    = 4'b0011,
    cmd_write     = 4'b0100,
    cmd_read      = 4'b0101,
    cmd_nop       = 4'b0111
  } sdram_cmd_e;

  // Kind of access held by the capture stage
  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1
  } op_e;

  // One request as the FPGA presents it
  typedef struct packed {
    logic [fpga_addr_w-1:0] addr;
    logic                   wr_en;
    logic [data_w-1:0]      wr_data;
  } fpga_req_t;

  // One cycle worth of SDRAM control pins
  typedef struct packed {
    sdram_cmd_e              cmd;
    logic                    clk_en;
    logic [bank_w-1:0]       bank;
    logic [sdram_addr_w-1:0] addr;
  } sdram_pins_t;

  // Mode register layout on A11..A0
  typedef struct packed {
    logic [1:0] reserved;
    logic       wr_burst_mode;
    logic [1:0] op_mode;
    logic [2:0] cas_latency;
    logic       burst_type;
    logic [2:0] burst_len;
  } mode_word_t;

  // Column command layout, A10 selects auto precharge
  typedef struct packed {
    logic             unused_hi;
    logic             auto_pre;
    logic             unused_lo;
    logic [col_w-1:0] col;
  } col_word_t;

  // Same address pins, decoded per command
  typedef union packed {
    mode_word_t       mode;
    col_word_t        col;
    logic [row_w-1:0] row;
  } sdram_addr_u;

endpackage

`default_nettype wire

/* design/sdram_req_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_req_capture (
  input  logic                          fpga_clk,
  input  logic                          fpga_reset,
  input  logic                          req,
  input  sdram_pkg::fpga_req_t          req_data,
  input  logic                          accept,
  input  logic                          issue_col,
  output logic                          req_pending,
  output sdram_pkg::op_e                op,
  output logic [sdram_pkg::bank_w-1:0]  bank,
  output logic [sdram_pkg::row_w-1:0]   row,
  output logic [sdram_pkg::col_w-1:0]   col,
  output logic [sdram_pkg::data_w-1:0]  wr_data
);

  // Local copy so the FPGA bus may move on after ack
  sdram_pkg::fpga_req_t req_q;
  logic                 take;

  // Sequencer has room and the requester has something
  assign take = accept && req;

  // Pending flag lives from capture until the column command
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      req_pending <= 1'b0;
    end else if (take) begin
      req_pending <= 1'b1;
    end else if (issue_col) begin
      req_pending <= 1'b0;
    end
  end

  // Payload copy
  always_ff @(posedge fpga_clk) begin
    if (take) begin
      req_q <= req_data;
    end
  end

  // Address split, bank on top, column at the bottom
  assign bank    = req_q.addr[sdram_pkg::col_w + sdram_pkg::row_w +: sdram_pkg::bank_w];
  assign row     = req_q.addr[sdram_pkg::col_w +: sdram_pkg::row_w];
  assign col     = req_q.addr[0 +: sdram_pkg::col_w];
  assign op      = req_q.wr_en ? sdram_pkg::op_write : sdram_pkg::op_read;
  assign wr_data = req_q.wr_data;

endmodule

`default_nettype wire

/* design/sdram_refresh_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_refresh_timer #(
  parameter int refresh_cycles = 1040
) (
  input  logic fpga_clk,
  input  logic fpga_reset,
  input  logic refresh_issued,
  output logic refresh_due
);

  localparam int cnt_w = $clog2(refresh_cycles + 1);

  // Cycles since the last REFRESH went out
  logic [cnt_w-1:0] cnt;

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      cnt         <= '0;
      refresh_due <= 1'b0;
    end else if (refresh_issued) begin
      // Restart on every refresh, init ones included
      cnt         <= '0;
      refresh_due <= 1'b0;
    end else if (!refresh_due) begin
      cnt <= cnt + 1'b1;
      // Flag holds until the sequencer serves it
      if (cnt == cnt_w'(refresh_cycles - 1)) begin
        refresh_due <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/sdram_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_sequencer #(
  parameter int init_wait   = 33200,
  parameter int trp         = 3,
  parameter int trc         = 10,
  parameter int tmrd        = 3,
  parameter int trcd        = 3,
  parameter int twr         = 2,
  parameter int cas_latency = 2
) (
  input  logic                          fpga_clk,
  input  logic                          fpga_reset,
  input  logic                          req,
  input  sdram_pkg::op_e                op,
  input  logic [sdram_pkg::bank_w-1:0]  bank,
  input  logic [sdram_pkg::row_w-1:0]   row,
  input  logic [sdram_pkg::col_w-1:0]   col,
  input  logic                          refresh_due,
  output logic                          accept,
  output logic                          issue_col,
  output logic                          ack,
  output logic                          refresh_issued,
  output logic                          capture_read,
  output sdram_pkg::sdram_pins_t        pins_next
);

  // Init command points, counted from reset
  localparam int t_ref1    = init_wait + trp;
  localparam int t_ref2    = t_ref1 + trc;
  localparam int t_mode    = t_ref2 + trc;
  // Counter must reach the init end and every hold
  localparam int cnt_w     = $clog2(t_mode + twr + trp + cas_latency + tmrd + trcd + 2);

  typedef enum logic [2:0] {
    st_init,
    st_mode,
    st_idle,
    st_refresh,
    st_activate,
    st_read,
    st_write
  } state_e;

  state_e                 state;
  state_e                 next_state;
  logic [cnt_w-1:0]       wait_cnt;
  logic                   at_decision;

  // Address words, one per command that uses the pins
  sdram_pkg::sdram_addr_u pre_all_word;
  sdram_pkg::sdram_addr_u mode_word;
  sdram_pkg::sdram_addr_u row_word;
  sdram_pkg::sdram_addr_u col_word;

  always_comb begin
    // PRECHARGE ALL needs only A10
    pre_all_word                    = '0;
    pre_all_word.col.auto_pre       = 1'b1;
    // Burst of 1, sequential, single location writes
    mode_word                       = '0;
    mode_word.mode.wr_burst_mode    = 1'b1;
    mode_word.mode.cas_latency      = 3'(cas_latency);
    mode_word.mode.burst_type       = 1'b0;
    mode_word.mode.burst_len        = 3'b000;
    row_word.row                    = row;
    // Column access always closes the row
    col_word                        = '0;
    col_word.col.auto_pre           = 1'b1;
    col_word.col.col                = col;
  end

  // Next state and the command for the next pin cycle
  always_comb begin
    next_state  = state;
    at_decision = 1'b0;
    issue_col   = 1'b0;
    pins_next   = '{cmd: sdram_pkg::cmd_nop, clk_en: 1'b1, bank: '0, addr: '0};

    case (state)
      st_init: begin
        if (wait_cnt == cnt_w'(init_wait)) begin
          pins_next.cmd  = sdram_pkg::cmd_precharge;
          pins_next.addr = pre_all_word;
        end else if (wait_cnt == cnt_w'(t_ref1) || wait_cnt == cnt_w'(t_ref2)) begin
          pins_next.cmd  = sdram_pkg::cmd_refresh;
        end else if (wait_cnt == cnt_w'(t_mode)) begin
          pins_next.cmd  = sdram_pkg::cmd_load_mode;
          pins_next.addr = mode_word;
          next_state     = st_mode;
        end
      end

      // Mode register programming time
      st_mode: begin
        if (wait_cnt == cnt_w'(tmrd - 1)) begin
          next_state = st_idle;
        end
      end

      st_idle: begin
        at_decision = 1'b1;
      end

      st_refresh: begin
        at_decision = (wait_cnt == cnt_w'(trc - 1));
      end

      // Row open, column command after trcd
      st_activate: begin
        if (wait_cnt == cnt_w'(trcd - 1)) begin
          issue_col      = 1'b1;
          pins_next.bank = bank;
          pins_next.addr = col_word;
          if (op == sdram_pkg::op_write) begin
            pins_next.cmd = sdram_pkg::cmd_write;
            next_state    = st_write;
          end else begin
            pins_next.cmd = sdram_pkg::cmd_read;
            next_state    = st_read;
          end
        end
      end

      // Data returns, then auto precharge finishes
      st_read: begin
        at_decision = (wait_cnt == cnt_w'(cas_latency + trp - 1));
      end

      // Write recovery plus auto precharge
      st_write: begin
        at_decision = (wait_cnt == cnt_w'(twr + trp - 1));
      end

      default: begin
        next_state = st_init;
      end
    endcase

    // Refresh wins over a pending request
    if (at_decision) begin
      if (refresh_due) begin
        pins_next.cmd = sdram_pkg::cmd_refresh;
        next_state    = st_refresh;
      end else if (req) begin
        pins_next.cmd  = sdram_pkg::cmd_active;
        pins_next.bank = bank;
        pins_next.addr = row_word;
        next_state     = st_activate;
      end else begin
        next_state = st_idle;
      end
    end
  end

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      state    <= st_init;
      wait_cnt <= '0;
    end else begin
      state <= next_state;
      // Counter restarts on every state change
      if (next_state != state) begin
        wait_cnt <= '0;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Take a new request once init is done and nothing is held
  assign accept         = !req && (state != st_init) && (state != st_mode);
  assign ack            = issue_col;
  assign capture_read   = issue_col && (op == sdram_pkg::op_read);
  assign refresh_issued = (pins_next.cmd == sdram_pkg::cmd_refresh);

endmodule

`default_nettype wire

/* design/sdram_pin_driver.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_pin_driver #(
  parameter int cas_latency = 2
) (
  input  logic                                fpga_clk,
  input  logic                                fpga_reset,
  input  sdram_pkg::sdram_pins_t              pins_next,
  input  logic [sdram_pkg::data_w-1:0]        wr_data,
  input  logic                                capture_read,
  output logic                                ram_clk,
  output logic                                ram_clk_en,
  output logic                                ram_cs_n,
  output logic                                ram_ras_n,
  output logic                                ram_cas_n,
  output logic                                ram_we_n,
  output logic [sdram_pkg::bank_w-1:0]        ram_bank,
  output logic [sdram_pkg::sdram_addr_w-1:0]  ram_addr,
  inout  wire  [sdram_pkg::data_w-1:0]        ram_data,
  output logic [sdram_pkg::data_w-1:0]        rd_data,
  output logic                                rd_valid
);

  sdram_pkg::sdram_pins_t      pins_q;
  logic                        wr_oe;
  logic [sdram_pkg::data_w-1:0] wr_q;
  // One bit per cycle of CAS latency
  logic [cas_latency-1:0]      rd_pipe;

  // Pin registers, NOP with clock enable low out of reset
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      pins_q <= '{cmd: sdram_pkg::cmd_nop, clk_en: 1'b0, bank: '0, addr: '0};
      wr_oe  <= 1'b0;
    end else begin
      pins_q <= pins_next;
      // Bus driven only while WRITE is on the pins
      wr_oe  <= (pins_next.cmd == sdram_pkg::cmd_write);
    end
  end

  always_ff @(posedge fpga_clk) begin
    wr_q <= wr_data;
  end

  // Inverted clock so the SDRAM samples in mid cycle
  assign ram_clk    = ~fpga_clk;
  assign ram_clk_en = pins_q.clk_en;
  assign {ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n} = pins_q.cmd;
  assign ram_bank   = pins_q.bank;
  assign ram_addr   = pins_q.addr;
  assign ram_data   = wr_oe ? wr_q : 'z;

  // Read return, sampled once at the end of the latency
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      rd_pipe  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_pipe  <= cas_latency'({rd_pipe, capture_read});
      rd_valid <= rd_pipe[cas_latency-1];
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (rd_pipe[cas_latency-1]) begin
      rd_data <= ram_data;
    end
  end

endmodule

`default_nettype wire

/* design/sdram_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_controller #(
  parameter int clk_mhz       = 166,
  parameter int t_power_up_ns = 200000,
  parameter int t_rp_ns       = 18,
  parameter int t_rc_ns       = 60,
  parameter int t_mrd_ns      = 18,
  parameter int t_rcd_ns      = 18,
  parameter int t_wr_ns       = 12,
  // Per row interval, 64 ms over 4096 rows
  parameter int t_refresh_ns  = 15625,
  parameter int cas_latency   = 2
) (
  input  logic                                fpga_clk,
  input  logic                                fpga_reset,
  input  logic                                req,
  input  sdram_pkg::fpga_req_t                req_data,
  output logic                                ack,
  output logic [sdram_pkg::data_w-1:0]        rd_data,
  output logic                                rd_valid,
  output logic                                ram_clk,
  output logic                                ram_clk_en,
  output logic                                ram_cs_n,
  output logic                                ram_ras_n,
  output logic                                ram_cas_n,
  output logic                                ram_we_n,
  output logic [sdram_pkg::bank_w-1:0]        ram_bank,
  output logic [sdram_pkg::sdram_addr_w-1:0]  ram_addr,
  inout  wire  [sdram_pkg::data_w-1:0]        ram_data
);

  // Nanoseconds to whole cycles, rounded up, never zero
  function automatic int to_cycles(input int ns);
    int c;
    c = (ns * clk_mhz + 999) / 1000;
    return (c < 1) ? 1 : c;
  endfunction

  localparam int init_wait      = to_cycles(t_power_up_ns);
  localparam int trp            = to_cycles(t_rp_ns);
  localparam int trc            = to_cycles(t_rc_ns);
  localparam int tmrd           = to_cycles(t_mrd_ns);
  localparam int trcd           = to_cycles(t_rcd_ns);
  localparam int twr            = to_cycles(t_wr_ns);
  localparam int refresh_cycles = to_cycles(t_refresh_ns);

  logic                           req_pending;
  sdram_pkg::op_e                 op;
  logic [sdram_pkg::bank_w-1:0]   bank;
  logic [sdram_pkg::row_w-1:0]    row;
  logic [sdram_pkg::col_w-1:0]    col;
  logic [sdram_pkg::data_w-1:0]   wr_data;
  logic                           accept;
  logic                           issue_col;
  logic                           refresh_issued;
  logic                           refresh_due;
  logic                           capture_read;
  sdram_pkg::sdram_pins_t         pins_next;

  // Input side
  sdram_req_capture u_capture (
    .fpga_clk    (fpga_clk),
    .fpga_reset  (fpga_reset),
    .req         (req),
    .req_data    (req_data),
    .accept      (accept),
    .issue_col   (issue_col),
    .req_pending (req_pending),
    .op          (op),
    .bank        (bank),
    .row         (row),
    .col         (col),
    .wr_data     (wr_data)
  );

  sdram_refresh_timer #(
    .refresh_cycles (refresh_cycles)
  ) u_refresh (
    .fpga_clk       (fpga_clk),
    .fpga_reset     (fpga_reset),
    .refresh_issued (refresh_issued),
    .refresh_due    (refresh_due)
  );

  // Command FSM
  sdram_sequencer #(
    .init_wait   (init_wait),
    .trp         (trp),
    .trc         (trc),
    .tmrd        (tmrd),
    .trcd        (trcd),
    .twr         (twr),
    .cas_latency (cas_latency)
  ) u_sequencer (
    .fpga_clk       (fpga_clk),
    .fpga_reset     (fpga_reset),
    .req            (req_pending),
    .op             (op),
    .bank           (bank),
    .row            (row),
    .col            (col),
    .refresh_due    (refresh_due),
    .accept         (accept),
    .issue_col      (issue_col),
    .ack            (ack),
    .refresh_issued (refresh_issued),
    .capture_read   (capture_read),
    .pins_next      (pins_next)
  );

  // Output side
  sdram_pin_driver #(
    .cas_latency (cas_latency)
  ) u_pins (
    .fpga_clk     (fpga_clk),
    .fpga_reset   (fpga_reset),
    .pins_next    (pins_next),
    .wr_data      (wr_data),
    .capture_read (capture_read),
    .ram_clk      (ram_clk),
    .ram_clk_en   (ram_clk_en),
    .ram_cs_n     (ram_cs_n),
    .ram_ras_n    (ram_ras_n),
    .ram_cas_n    (ram_cas_n),
    .ram_we_n     (ram_we_n),
    .ram_bank     (ram_bank),
    .ram_addr     (ram_addr),
    .ram_data     (ram_data),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid)
  );

endmodule

`default_nettype wire

/* dv/sdram_model.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_model #(
  parameter int cas_latency   = 2,
  parameter int trc_cycles    = 2,
  parameter int clk_period_ns = 40
) (
  input  wire                                 ram_clk,
  input  wire                                 ram_clk_en,
  input  wire                                 ram_cs_n,
  input  wire                                 ram_ras_n,
  input  wire                                 ram_cas_n,
  input  wire                                 ram_we_n,
  input  wire  [sdram_pkg::bank_w-1:0]        ram_bank,
  input  wire  [sdram_pkg::sdram_addr_w-1:0]  ram_addr,
  inout  wire  [sdram_pkg::data_w-1:0]        ram_data
);

  // Storage, unwritten words read back as zero
  logic [sdram_pkg::data_w-1:0]      mem [logic [sdram_pkg::fpga_addr_w-1:0]];
  logic [sdram_pkg::row_w-1:0]       open_row [0:3];
  logic [3:0]                        cmd;
  logic [sdram_pkg::fpga_addr_w-1:0] key;

  // First commands after power-up, for the init order check
  logic [3:0]                        init_cmd [0:3];
  logic [sdram_pkg::sdram_addr_w-1:0] init_addr [0:3];
  int                                log_count = 0;
  int                                act_before_mode = 0;
  bit                                mode_seen = 1'b0;
  logic [sdram_pkg::sdram_addr_w-1:0] mode_word;

  // Refresh bookkeeping
  int                                refresh_count = 0;
  realtime                           last_ref = 0.0;
  realtime                           max_ref_gap = 0.0;
  int                                act_in_trc = 0;

  // Read return pipeline, one stage per latency cycle after the first
  logic                              rd_vld [0:3];
  logic [sdram_pkg::data_w-1:0]      rd_word [0:3];
  logic                              dq_oe = 1'b0;
  logic [sdram_pkg::data_w-1:0]      dq_out;

  initial begin
    for (int i = 0; i < 4; i++) begin
      rd_vld[i] = 1'b0;
    end
  end

  assign ram_data = dq_oe ? dq_out : 'z;

  always @(posedge ram_clk) begin
    cmd = {ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n};
    // Data is driven from edge CL-1 until edge CL
    dq_oe  <= rd_vld[cas_latency-2];
    dq_out <= rd_word[cas_latency-2];
    for (int i = 3; i > 0; i--) begin
      rd_vld[i]  <= rd_vld[i-1];
      rd_word[i] <= rd_word[i-1];
    end
    rd_vld[0] <= 1'b0;

    if (ram_clk_en && cmd != sdram_pkg::cmd_nop) begin
      if (log_count < 4) begin
        init_cmd[log_count]  = cmd;
        init_addr[log_count] = ram_addr;
        log_count++;
        $display("sdram_model: %0t init command %b addr %h", $time, cmd, ram_addr);
      end
      case (cmd)
        sdram_pkg::cmd_active: begin
          open_row[ram_bank] = ram_addr;
          if (!mode_seen) begin
            act_before_mode++;
          end
          // Row open too soon after a refresh
          if (refresh_count > 0 && ($realtime - last_ref) < trc_cycles * clk_period_ns) begin
            act_in_trc++;
          end
        end
        sdram_pkg::cmd_write: begin
          key      = {ram_bank, open_row[ram_bank], ram_addr[sdram_pkg::col_w-1:0]};
          mem[key] = ram_data;
        end
        sdram_pkg::cmd_read: begin
          key        = {ram_bank, open_row[ram_bank], ram_addr[sdram_pkg::col_w-1:0]};
          rd_vld[0]  <= 1'b1;
          rd_word[0] <= mem.exists(key) ? mem[key] : '0;
        end
        sdram_pkg::cmd_refresh: begin
          if (refresh_count > 0 && ($realtime - last_ref) > max_ref_gap) begin
            max_ref_gap = $realtime - last_ref;
          end
          last_ref = $realtime;
          refresh_count++;
        end
        sdram_pkg::cmd_load_mode: begin
          mode_seen = 1'b1;
          mode_word = ram_addr;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* dv/sdram_controller_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_controller_tb;

  localparam int clk_period  = 40;
  localparam int cas_latency = 2;
  // Cycle counts at 25 MHz rounded up
  localparam int init_wait   = 50;
  localparam int trp         = 1;
  localparam int trc         = 2;
  localparam int tmrd        = 1;
  localparam int trcd        = 1;
  localparam int twr         = 1;
  localparam int refresh_cyc = 1000;
  // Early write, two directed, 100 random, 10 reads, refresh loop cap
  localparam int max_requests = 1 + 2 + 100 + 10 + 600;
  // Worst case per request including a refresh in the way
  localparam int max_latency = trc + 2 + trcd + cas_latency + twr + trp + 6;
  localparam int init_cycles = 10 + init_wait + trp + 2 * trc + tmrd + 5;
  localparam int timeout_ns  = (init_cycles + max_requests * max_latency) * 3 / 2 * clk_period;
  // Activate plus read hold plus flag latency
  localparam int longest_access = 1 + trcd + cas_latency + trp + 2;
  localparam real gap_bound_ns = (refresh_cyc + longest_access) * clk_period;

  logic                               fpga_clk;
  logic                               fpga_reset;
  logic                               req;
  sdram_pkg::fpga_req_t               req_data;
  logic                               ack;
  logic [sdram_pkg::data_w-1:0]       rd_data;
  logic                               rd_valid;
  wire                                ram_clk;
  wire                                ram_clk_en;
  wire                                ram_cs_n;
  wire                                ram_ras_n;
  wire                                ram_cas_n;
  wire                                ram_we_n;
  wire  [sdram_pkg::bank_w-1:0]       ram_bank;
  wire  [sdram_pkg::sdram_addr_w-1:0] ram_addr;
  wire  [sdram_pkg::data_w-1:0]       ram_data;

  // Scoreboard state
  int                                 errors = 0;
  int                                 fails = 0;
  int                                 ack_count = 0;
  int                                 cycle = 0;
  int                                 start_err;
  int                                 start_ref;
  int                                 start_ack;
  int                                 n;
  // Requests driven but not yet acked
  sdram_pkg::fpga_req_t               issued_q [$];
  sdram_pkg::fpga_req_t               r_cmp;
  // Reads acked and waiting for rd_valid
  logic [sdram_pkg::data_w-1:0]       exp_q [$];
  int                                 ack_cyc_q [$];
  logic [sdram_pkg::data_w-1:0]       ref_mem [logic [sdram_pkg::fpga_addr_w-1:0]];

  sdram_controller #(
    .clk_mhz       (25),
    .t_power_up_ns (2000),
    .t_refresh_ns  (40000),
    .cas_latency   (cas_latency)
  ) dut (
    .fpga_clk   (fpga_clk),
    .fpga_reset (fpga_reset),
    .req        (req),
    .req_data   (req_data),
    .ack        (ack),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .ram_clk    (ram_clk),
    .ram_clk_en (ram_clk_en),
    .ram_cs_n   (ram_cs_n),
    .ram_ras_n  (ram_ras_n),
    .ram_cas_n  (ram_cas_n),
    .ram_we_n   (ram_we_n),
    .ram_bank   (ram_bank),
    .ram_addr   (ram_addr),
    .ram_data   (ram_data)
  );

  sdram_model #(
    .cas_latency   (cas_latency),
    .trc_cycles    (trc),
    .clk_period_ns (clk_period)
  ) ram_model (
    .ram_clk    (ram_clk),
    .ram_clk_en (ram_clk_en),
    .ram_cs_n   (ram_cs_n),
    .ram_ras_n  (ram_ras_n),
    .ram_cas_n  (ram_cas_n),
    .ram_we_n   (ram_we_n),
    .ram_bank   (ram_bank),
    .ram_addr   (ram_addr),
    .ram_data   (ram_data)
  );

  initial begin
    fpga_clk = 1'b0;
  end

  always #(clk_period / 2) fpga_clk = ~fpga_clk;

  // Cycle count for the read latency check
  always @(posedge fpga_clk) begin
    cycle <= cycle + 1;
  end

  // A write stores the word and a read returns the last one stored
  function automatic logic [31:0] ref_access(input logic [22:0] addr, input logic wr,
                                             input logic [31:0] data);
    if (wr) begin
      ref_mem[addr] = data;
      return data;
    end
    return ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Acks pair with requests in order and reads then wait for rd_valid
  always @(negedge fpga_clk) begin
    if (!fpga_reset) begin
      if (ack) begin
        ack_count++;
        if (issued_q.size() == 0) begin
          $display("ERROR at %0t ns: ack seen with no request outstanding", $time);
          errors++;
        end else begin
          r_cmp = issued_q.pop_front();
          if (r_cmp.wr_en) begin
            void'(ref_access(r_cmp.addr, 1'b1, r_cmp.wr_data));
          end else begin
            exp_q.push_back(ref_access(r_cmp.addr, 1'b0, '0));
            ack_cyc_q.push_back(cycle);
          end
        end
      end
      if (rd_valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t ns: read data arrived with no read outstanding", $time);
          errors++;
        end else begin
          check_value("rd_data", rd_data, exp_q.pop_front());
          check_value("rd_valid_latency", cycle - ack_cyc_q.pop_front(), cas_latency + 1);
        end
      end
    end
  end

  // Drive one request and hold it until ack
  task automatic issue_request(input logic [22:0] addr, input logic wr, input logic [31:0] data);
    sdram_pkg::fpga_req_t r;
    r.addr    = addr;
    r.wr_en   = wr;
    r.wr_data = data;
    @(negedge fpga_clk);
    req      = 1'b1;
    req_data = r;
    issued_q.push_back(r);
    @(negedge fpga_clk);
    while (!ack) begin
      @(negedge fpga_clk);
    end
    req = 1'b0;
  endtask

  // Small address set where every field takes several values
  function automatic logic [22:0] pick_addr();
    logic [11:0] rows [0:3];
    logic [8:0]  cols [0:3];
    rows = '{12'h000, 12'h001, 12'habc, 12'hfff};
    cols = '{9'h000, 9'h001, 9'h155, 9'h1ff};
    return {2'($urandom % 4), rows[$urandom % 4], cols[$urandom % 4]};
  endfunction

  // Drained once nothing waits for ack and no read waits for data
  task automatic wait_reads_done();
    while (issued_q.size() != 0 || exp_q.size() != 0) begin
      @(negedge fpga_clk);
    end
    repeat (2) @(negedge fpga_clk);
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
      fails++;
    end
  endtask

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", timeout_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(90382));
    fpga_reset = 1'b1;
    req        = 1'b0;
    req_data   = '0;
    repeat (10) @(posedge fpga_clk);
    @(negedge fpga_clk);
    fpga_reset = 1'b0;

    // Power-up order and the mode word
    start_err = errors;
    // Request already waiting while init runs
    req      = 1'b1;
    req_data = '{addr: {2'd1, 12'h456, 9'h0ab}, wr_en: 1'b1, wr_data: 32'h1234_5678};
    issued_q.push_back(req_data);
    while (!ram_model.mode_seen) begin
      @(negedge fpga_clk);
    end
    check_value("init_cmd0", ram_model.init_cmd[0], sdram_pkg::cmd_precharge);
    check_value("init_a10", ram_model.init_addr[0][10], 1'b1);
    check_value("init_cmd1", ram_model.init_cmd[1], sdram_pkg::cmd_refresh);
    check_value("init_cmd2", ram_model.init_cmd[2], sdram_pkg::cmd_refresh);
    check_value("init_cmd3", ram_model.init_cmd[3], sdram_pkg::cmd_load_mode);
    check_value("mode_cas", ram_model.mode_word[6:4], cas_latency);
    check_value("mode_burst_len", ram_model.mode_word[2:0], 0);
    check_value("act_before_mode", ram_model.act_before_mode, 0);
    // Early request is served once the mode is set
    while (!ack) begin
      @(negedge fpga_clk);
    end
    req = 1'b0;
    wait_reads_done();
    report_test(1, "init order", start_err);

    // Write then read back with one ack each
    start_err = errors;
    start_ack = ack_count;
    issue_request({2'd2, 12'h123, 9'h045}, 1'b1, 32'hdeadbeef);
    issue_request({2'd2, 12'h123, 9'h045}, 1'b0, 32'h0);
    wait_reads_done();
    check_value("ack_count", ack_count - start_ack, 2);
    report_test(2, "write then read", start_err);

    start_err = errors;
    for (int i = 0; i < 100; i++) begin
      issue_request(pick_addr(), 1'($urandom % 2), $urandom);
    end
    wait_reads_done();
    report_test(3, "random access", start_err);

    // Back-to-back reads
    start_err = errors;
    for (int i = 0; i < 10; i++) begin
      issue_request(pick_addr(), 1'b0, 32'h0);
    end
    wait_reads_done();
    report_test(4, "read timing", start_err);

    // Back-to-back traffic until two periodic refreshes are seen
    start_err = errors;
    start_ref = ram_model.refresh_count;
    n         = 0;
    while (ram_model.refresh_count < start_ref + 2 && n < 600) begin
      issue_request(pick_addr(), 1'($urandom % 2), $urandom);
      n++;
    end
    wait_reads_done();
    check_value("refreshes_seen", ram_model.refresh_count >= start_ref + 2, 1);
    check_value("refresh_gap_ok", ram_model.max_ref_gap <= gap_bound_ns, 1);
    check_value("act_in_trc", ram_model.act_in_trc, 0);
    report_test(5, "refresh under load", start_err);

    $display("tests run: 5, tests failed: %0d, checks failed: %0d", fails, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
design/sdram_pkg.sv
design/sdram_req_capture.sv
design/sdram_refresh_timer.sv
design/sdram_sequencer.sv
design/sdram_pin_driver.sv
design/sdram_controller.sv
dv/sdram_model.sv
dv/sdram_controller_tb.sv

/* Bender.yml */
package:
  name: sdram_controller

sources:
  - files:
      - design/sdram_pkg.sv
      - design/sdram_req_capture.sv
      - design/sdram_refresh_timer.sv
      - design/sdram_sequencer.sv
      - design/sdram_pin_driver.sv
      - design/sdram_controller.sv
  - target: simulation
    files:
      - dv/sdram_model.sv
      - dv/sdram_controller_tb.sv
